// File: files.f
hdl/pq_pkg.sv
hdl/pq_ctrl_if.sv
hdl/pq_control_fsm.sv
hdl/pq_slot_ram.sv
hdl/pq_datapath.sv
hdl/pq_top.sv
testbench/pq_checker.sv
testbench/pq_tb.sv

// File: hdl/pq_control_fsm.sv
module pq_control_fsm (
  input  logic  clk,
  input  logic  rst,
  pq_ctrl_if.fsm ctrl,
  input  logic  enq,
  input  logic  deq,
  output logic  busy,
  output logic  data_valid
);

  pq_pkg::pq_state_e state;
  pq_pkg::pq_state_e next_state;

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= pq_pkg::ST_IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  // Result strobe lines up with the data_out register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      data_valid <= 1'b0;
    end
    else
    begin
      data_valid <= (state == pq_pkg::ST_DEQ_OUT);
    end
  end

  // Any state but idle is a running operation
  assign busy = (state != pq_pkg::ST_IDLE);

  ////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    // Defaults keep every strobe quiet and the register unchanged
    next_state     = state;
    ctrl.load_sel  = pq_pkg::LOAD_HOLD;
    ctrl.ram_we    = 1'b0;
    ctrl.rd_en     = 1'b0;
    ctrl.idx_clr   = 1'b0;
    ctrl.idx_inc   = 1'b0;
    ctrl.cnt_inc   = 1'b0;
    ctrl.cnt_dec   = 1'b0;
    ctrl.out_load  = 1'b0;
    ctrl.addr_tail = 1'b0;

    case (state)
      pq_pkg::ST_IDLE:
      begin
        // Enqueue wins over dequeue
        // Take input, rewind index and fetch slot 0
        if (enq && !ctrl.full)
        begin
          ctrl.load_sel = pq_pkg::LOAD_INPUT;
          ctrl.idx_clr  = 1'b1;
          ctrl.rd_en    = 1'b1;
          next_state    = pq_pkg::ST_FILL;
        end
        else if (!enq && deq && !ctrl.empty)
        begin
          next_state = pq_pkg::ST_DEQ_READ;
        end
      end

      pq_pkg::ST_FILL:
      begin
        // Empty queue has nothing to scan
        next_state = ctrl.scan_end ? pq_pkg::ST_APPEND : pq_pkg::ST_COMPARE;
      end

      pq_pkg::ST_COMPARE:
      begin
        // Held value bigger than slot belongs here
        next_state = ctrl.greater ? pq_pkg::ST_SWAP : pq_pkg::ST_STEP;
      end

      pq_pkg::ST_SWAP:
      begin
        // Held value into slot and old slot value into register
        ctrl.ram_we   = 1'b1;
        ctrl.load_sel = pq_pkg::LOAD_RAM;
        next_state    = pq_pkg::ST_STEP;
      end

      pq_pkg::ST_STEP:
      begin
        ctrl.idx_inc = 1'b1;
        if (ctrl.scan_end)
        begin
          next_state = pq_pkg::ST_APPEND;
        end
        else
        begin
          // Fetch next slot for the following compare
          ctrl.rd_en = 1'b1;
          next_state = pq_pkg::ST_COMPARE;
        end
      end

      pq_pkg::ST_APPEND:
      begin
        // Leftover value is the smallest and goes to the first free slot
        ctrl.ram_we    = 1'b1;
        ctrl.addr_tail = 1'b1;
        ctrl.cnt_inc   = 1'b1;
        next_state     = pq_pkg::ST_IDLE;
      end

      pq_pkg::ST_DEQ_READ:
      begin
        // Smallest value sits in the last occupied slot
        ctrl.rd_en     = 1'b1;
        ctrl.addr_tail = 1'b1;
        next_state     = pq_pkg::ST_DEQ_OUT;
      end

      pq_pkg::ST_DEQ_OUT:
      begin
        ctrl.out_load = 1'b1;
        ctrl.cnt_dec  = 1'b1;
        next_state    = pq_pkg::ST_IDLE;
      end

      default:
      begin
        next_state = pq_pkg::ST_IDLE;
      end
    endcase
  end

endmodule

// File: hdl/pq_ctrl_if.sv
interface pq_ctrl_if;

  // Strobes from the FSM, recomputed every cycle
  pq_pkg::pq_load_e load_sel;
  logic             ram_we;
  logic             rd_en;
  logic             idx_clr;
  logic             idx_inc;
  logic             cnt_inc;
  logic             cnt_dec;
  logic             out_load;
  logic             addr_tail;

  // Status flags from the datapath
  logic greater;
  logic scan_end;
  logic full;
  logic empty;

  // Sequencer side
  modport fsm (
    output load_sel, ram_we, rd_en, idx_clr, idx_inc,
    output cnt_inc, cnt_dec, out_load, addr_tail,
    input  greater, scan_end, full, empty
  );

  // Datapath side
  modport dp (
    input  load_sel, ram_we, rd_en, idx_clr, idx_inc,
    input  cnt_inc, cnt_dec, out_load, addr_tail,
    output greater, scan_end, full, empty
  );

endinterface

// File: hdl/pq_datapath.sv
module pq_datapath (
  input  logic                      clk,
  input  logic                      rst,
  pq_ctrl_if.dp                     ctrl,
  input  logic [pq_pkg::DATA_W-1:0] data_in,
  output logic [pq_pkg::ADDR_W-1:0] ram_addr,
  output logic [pq_pkg::DATA_W-1:0] ram_wdata,
  input  logic [pq_pkg::DATA_W-1:0] ram_rdata,
  output logic [pq_pkg::DATA_W-1:0] data_out,
  output logic [pq_pkg::CNT_W-1:0]  count
);

  logic [pq_pkg::DATA_W-1:0] hold_q;
  logic [pq_pkg::ADDR_W-1:0] idx_q;
  // Index as seen after this cycle's step
  logic [pq_pkg::CNT_W-1:0]  idx_next;
  logic [pq_pkg::CNT_W-1:0]  tail;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Holding register
  always_ff @(posedge clk)
  begin
    case (ctrl.load_sel)
      pq_pkg::LOAD_INPUT: hold_q <= data_in;
      pq_pkg::LOAD_RAM:   hold_q <= ram_rdata;
      default:            hold_q <= hold_q;
    endcase
  end

  // Scan index and occupancy
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idx_q <= '0;
      count <= '0;
    end
    else
    begin
      if (ctrl.idx_clr)
      begin
        idx_q <= '0;
      end
      else if (ctrl.idx_inc)
      begin
        idx_q <= idx_q + 1'b1;
      end
      if (ctrl.cnt_inc)
      begin
        count <= count + 1'b1;
      end
      else if (ctrl.cnt_dec)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // Dequeue result, held until the next dequeue
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      data_out <= '0;
    end
    else if (ctrl.out_load)
    begin
      data_out <= ram_rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address, write data and flags
  ////////////////////////////////////////////////////////////

  assign idx_next = {1'b0, idx_q} + pq_pkg::CNT_W'(ctrl.idx_inc);

  // Append writes at count, dequeue reads at count - 1
  assign tail = ctrl.ram_we ? count : count - pq_pkg::CNT_W'(1);

  always_comb
  begin
    if (ctrl.idx_clr)
      ram_addr = '0;
    else if (ctrl.addr_tail)
      ram_addr = tail[pq_pkg::ADDR_W-1:0];
    else
      ram_addr = idx_next[pq_pkg::ADDR_W-1:0];
  end

  assign ram_wdata = hold_q;

  assign ctrl.greater  = (hold_q > ram_rdata);
  assign ctrl.scan_end = (idx_next == count);
  assign ctrl.full     = (count == pq_pkg::CNT_W'(pq_pkg::DEPTH));
  assign ctrl.empty    = (count == '0);

endmodule

// File: hdl/pq_pkg.sv
package pq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Entry width
  localparam int DATA_W = 16;

  // Number of slots in the block RAM
  localparam int DEPTH = 16;

  // Slot index width
  localparam int ADDR_W = $clog2(DEPTH);

  // Occupancy count, one extra bit so that DEPTH fits
  localparam int CNT_W = $clog2(DEPTH + 1);

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Holding register source
  typedef enum logic [1:0] {
    LOAD_INPUT = 2'b00,
    LOAD_RAM   = 2'b01,
    LOAD_HOLD  = 2'b10
  } pq_load_e;

  // Control FSM states
  typedef enum logic [3:0] {
    ST_IDLE     = 4'd0,
    ST_FILL     = 4'd1,
    ST_COMPARE  = 4'd2,
    ST_SWAP     = 4'd3,
    ST_STEP     = 4'd4,
    ST_APPEND   = 4'd5,
    ST_DEQ_READ = 4'd6,
    ST_DEQ_OUT  = 4'd7
  } pq_state_e;

endpackage

// File: hdl/pq_slot_ram.sv
module pq_slot_ram (
  input  logic                      clk,
  input  logic                      we,
  input  logic                      rd_en,
  input  logic [pq_pkg::ADDR_W-1:0] addr,
  input  logic [pq_pkg::DATA_W-1:0] wdata,
  output logic [pq_pkg::DATA_W-1:0] rdata
);

  // Sorted entries, largest at slot 0
  logic [pq_pkg::DATA_W-1:0] mem [pq_pkg::DEPTH];

  // Write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= wdata;
    end
  end

  // Registered read, output holds between reads
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: hdl/pq_top.sv
module pq_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enq,
  input  logic                      deq,
  input  logic [pq_pkg::DATA_W-1:0] data_in,
  output logic [pq_pkg::DATA_W-1:0] data_out,
  output logic                      data_valid,
  output logic                      busy,
  output logic                      full,
  output logic                      empty,
  output logic [pq_pkg::CNT_W-1:0]  count
);

  // Datapath to RAM
  logic [pq_pkg::ADDR_W-1:0] ram_addr;
  logic [pq_pkg::DATA_W-1:0] ram_wdata;
  logic [pq_pkg::DATA_W-1:0] ram_rdata;

  pq_ctrl_if ctrl_if ();

  pq_control_fsm u_control_fsm (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl_if.fsm),
    .enq        (enq),
    .deq        (deq),
    .busy       (busy),
    .data_valid (data_valid)
  );

  pq_datapath u_datapath (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl_if.dp),
    .data_in   (data_in),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .data_out  (data_out),
    .count     (count)
  );

  // Strobes straight from the FSM
  pq_slot_ram u_slot_ram (
    .clk   (clk),
    .we    (ctrl_if.ram_we),
    .rd_en (ctrl_if.rd_en),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  // Status flags
  assign full  = ctrl_if.full;
  assign empty = ctrl_if.empty;

endmodule

// File: testbench/pq_checker.sv
module pq_checker (
  input logic                     clk,
  input logic                     rst,
  input pq_pkg::pq_state_e        state,
  input logic                     data_valid,
  input logic                     ram_we,
  input logic [pq_pkg::CNT_W-1:0] count
);

  // Failed assertions so far, read by the testbench
  int unsigned fail_count = 0;

  // Only the eight defined encodings
  legal_state: assert property (
    @(posedge clk) disable iff (rst)
    state inside {pq_pkg::ST_IDLE, pq_pkg::ST_FILL, pq_pkg::ST_COMPARE,
                  pq_pkg::ST_SWAP, pq_pkg::ST_STEP, pq_pkg::ST_APPEND,
                  pq_pkg::ST_DEQ_READ, pq_pkg::ST_DEQ_OUT}
  )
  else
  begin
    $error("FSM state outside the defined encodings");
    fail_count++;
  end

  // Result strobe is a one-cycle pulse
  valid_pulse: assert property (
    @(posedge clk) disable iff (rst)
    data_valid |=> !data_valid
  )
  else
  begin
    $error("data_valid high for more than one cycle");
    fail_count++;
  end

  // RAM written only by swap and append
  write_state: assert property (
    @(posedge clk) disable iff (rst)
    ram_we |-> (state == pq_pkg::ST_SWAP || state == pq_pkg::ST_APPEND)
  )
  else
  begin
    $error("RAM write outside ST_SWAP and ST_APPEND");
    fail_count++;
  end

  // Occupancy bounded by the slot count
  count_bound: assert property (
    @(posedge clk) disable iff (rst)
    count <= pq_pkg::CNT_W'(pq_pkg::DEPTH)
  )
  else
  begin
    $error("count above DEPTH");
    fail_count++;
  end

endmodule

// FSM state, its strobes and the datapath count all meet at the top level
bind pq_top pq_checker u_checker (
  .clk        (clk),
  .rst        (rst),
  .state      (u_control_fsm.state),
  .data_valid (data_valid),
  .ram_we     (ctrl_if.ram_we),
  .count      (count)
);

// File: testbench/pq_input.txt
# Columns: command letter, hex value. E enqueue, D dequeue and expect value
# N dequeue on empty queue, F expect full, Z expect empty (value unused for N F Z)
Z 0
N 0
# Arbitrary order, ascending out
E 0042
E 0007
E 1234
E 0100
D 0007
D 0042
D 0100
D 1234
Z 0
# Duplicates, head, tail and middle inserts
E 0050
E 0050
E 0090
E 0010
E 0070
E 0050
D 0010
D 0050
D 0050
D 0050
D 0070
D 0090
Z 0
# Fill all slots, then one dropped enqueue
E 0031
E 0c00
E 0002
E ffff
E 0400
E 0020
E 0003
E 0800
E 0010
E 0005
E 0000
E 0100
E 0200
E 0040
E 0080
E 0004
F 0
E 0001
F 0
D 0000
D 0002
D 0003
D 0004
D 0005
D 0010
D 0020
D 0031
D 0040
D 0080
D 0100
D 0200
D 0400
D 0800
D 0c00
D ffff
Z 0
# Interleaved, smallest present each time
E 0300
E 0020
D 0020
E 0005
E 0400
D 0005
E 0001
D 0001
D 0300
E 0200
D 0200
D 0400
Z 0
N 0

// File: testbench/pq_tb.sv
module pq_tb;

  logic                      clk;
  logic                      rst;
  logic                      enq;
  logic                      deq;
  logic [pq_pkg::DATA_W-1:0] data_in;
  logic [pq_pkg::DATA_W-1:0] data_out;
  logic                      data_valid;
  logic                      busy;
  logic                      full;
  logic                      empty;
  logic [pq_pkg::CNT_W-1:0]  count;

  // Occupancy expected from the commands so far
  int model_count;
  // Upper bound in cycles for every wait loop
  int wait_limit = 100;

  pq_top u_pq_top (
    .clk        (clk),
    .rst        (rst),
    .enq        (enq),
    .deq        (deq),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_valid (data_valid),
    .busy       (busy),
    .full       (full),
    .empty      (empty),
    .count      (count)
  );

  // 20 unit period
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Error exits
  ////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Wrong value on a DUT output
  task automatic value_error(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    stop_run();
  endtask

  // Hangs, bad stimulus file and the like
  task automatic run_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    stop_run();
  endtask

  // Failures seen by the bound checker up to the previous edge
  always @(posedge clk)
  begin
    assert (u_pq_top.u_checker.fail_count == 0)
    else
      run_error("a concurrent assertion of the bound checker failed");
  end

  ////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////

  task automatic push_value(input logic [pq_pkg::DATA_W-1:0] value);
    int cycles;
    @(posedge clk);
    enq     <= 1'b1;
    data_in <= value;
    // DUT samples enq on this edge
    @(posedge clk);
    enq <= 1'b0;
    cycles = 0;
    @(negedge clk);
    // Busy only if there was room
    assert (busy == (model_count < pq_pkg::DEPTH))
    else
      value_error($sformatf("busy %b after enqueue with count %0d", busy, model_count));
    while (busy && cycles < wait_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    assert (!busy)
    else
      run_error("enqueue never finished, busy stayed high");
    if (model_count < pq_pkg::DEPTH)
    begin
      model_count++;
    end
    assert (count == model_count)
    else
      value_error($sformatf("count %0d after enqueue of %h, expected %0d",
                            count, value, model_count));
  endtask

  task automatic pop_and_check(input logic [pq_pkg::DATA_W-1:0] expected);
    int cycles;
    @(posedge clk);
    deq <= 1'b1;
    @(posedge clk);
    deq <= 1'b0;
    cycles = 0;
    @(negedge clk);
    assert (busy)
    else
      value_error("busy low in the first dequeue cycle");
    // Count edges after the one that sampled deq
    while (!data_valid && cycles < wait_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    assert (data_valid)
    else
      run_error("dequeue never produced data_valid");
    assert (cycles == 2)
    else
      value_error($sformatf("data_valid %0d cycles after deq, expected 2", cycles));
    if (model_count > 0)
    begin
      model_count--;
    end
    assert (data_out == expected)
    else
      value_error($sformatf("data_out %h, expected %h", data_out, expected));
    assert (count == model_count)
    else
      value_error($sformatf("count %0d after dequeue, expected %0d", count, model_count));
  endtask

  task automatic pop_when_empty();
    int cycles;
    @(posedge clk);
    deq <= 1'b1;
    @(posedge clk);
    deq <= 1'b0;
    // Nothing may respond in a short window
    for (cycles = 0; cycles < 4; cycles++)
    begin
      @(negedge clk);
      assert (!data_valid && !busy)
      else
        value_error("dequeue on an empty queue got a response");
    end
    assert (count == model_count)
    else
      value_error($sformatf("count %0d after empty dequeue, expected %0d", count, model_count));
  endtask

  task automatic expect_full();
    @(negedge clk);
    assert (full && !empty && count == pq_pkg::DEPTH)
    else
      value_error($sformatf("full %b empty %b count %0d, expected a full queue",
                            full, empty, count));
  endtask

  task automatic expect_empty();
    @(negedge clk);
    assert (empty && !full && count == 0)
    else
      value_error($sformatf("full %b empty %b count %0d, expected an empty queue",
                            full, empty, count));
  endtask

  task automatic run_command(input logic [7:0] cmd, input logic [pq_pkg::DATA_W-1:0] value);
    case (cmd)
      "E": push_value(value);
      "D": pop_and_check(value);
      "N": pop_when_empty();
      "F": expect_full();
      "Z": expect_empty();
      default: run_error($sformatf("unknown command '%s' in stimulus file", cmd));
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int                        fd;
    int                        code;
    int                        ch;
    logic [7:0]                cmd;
    logic [pq_pkg::DATA_W-1:0] value;
    bit                        done;
    clk         = 1'b0;
    rst         = 1'b1;
    enq         = 1'b0;
    deq         = 1'b0;
    data_in     = '0;
    model_count = 0;
    fd = $fopen("testbench/pq_input.txt", "r");
    assert (fd != 0)
    else
      run_error("could not open testbench/pq_input.txt");
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (empty && !full && count == 0 && !busy && !data_valid && data_out == '0)
    else
      value_error("outputs not in their reset state");
    done = 1'b0;
    while (!done)
    begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1)
      begin
        done = 1'b1;
      end
      else if (cmd == "#")
      begin
        // Skip a comment line to its end
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1)
        begin
          ch = $fgetc(fd);
        end
      end
      else
      begin
        code = $fscanf(fd, " %h", value);
        assert (code == 1)
        else
          run_error("stimulus file line has no value column");
        run_command(cmd, value);
      end
    end
    $fclose(fd);
    // One more sampling edge for the checker
    @(posedge clk);
    @(negedge clk);
    if (u_pq_top.u_checker.fail_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      run_error("a concurrent assertion of the bound checker failed");
    end
  end

endmodule
